// File: include/mem_request_settings.svh
// Build-time sizing of the memory request arbiter, included by the package and the RTL blocks
`ifndef MEM_REQUEST_SETTINGS_SVH
`define MEM_REQUEST_SETTINGS_SVH

// ------------------------------------------------------------
// Requesters and packet fields
// ------------------------------------------------------------
// Engine lanes sharing the memory request path
`define MEM_NUM_REQUESTORS 4
`define MEM_ADDR_WIDTH 32
`define MEM_DATA_WIDTH 32

// ------------------------------------------------------------
// Request FIFO
// ------------------------------------------------------------
`define MEM_FIFO_DEPTH 32
// Leaves 8 free entries for packets already granted
`define MEM_FIFO_PROG_THRESH 24

`endif

// File: hdl/mem_request_pkg.sv
// Shared request types for the arbiter RTL and testbench, imported by wildcard in module headers
`include "mem_request_settings.svh"

package mem_request_pkg;

  // ------------------------------------------------------------
  // Widths derived from the settings header
  // ------------------------------------------------------------
  // Source id needs at least one bit, even for a single lane
  localparam int MEM_SOURCE_WIDTH =
    (`MEM_NUM_REQUESTORS > 1) ? $clog2(`MEM_NUM_REQUESTORS) : 1;

  // ------------------------------------------------------------
  // Command encoding
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    CMD_MEM_READ     = 2'd0,
    CMD_MEM_WRITE    = 2'd1,
    // Travels back from memory, never queued toward it
    CMD_MEM_RESPONSE = 2'd2,
    CMD_MEM_FLUSH    = 2'd3
  } mem_cmd_t;

  // Field vectors
  typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [`MEM_DATA_WIDTH-1:0] mem_data_t;
  // Originating lane
  typedef logic [MEM_SOURCE_WIDTH-1:0] mem_source_t;

  // ------------------------------------------------------------
  // FIFO entry
  // ------------------------------------------------------------
  typedef struct packed {
    mem_cmd_t    cmd;
    mem_source_t source;
    mem_addr_t   address;
    mem_data_t   data;
  } mem_payload_t;

endpackage

// File: hdl/mem_request_if.sv
// One request packet as it moves between blocks inside the design, with source and sink views
`timescale 1ns/1ps

interface mem_request_if import mem_request_pkg::*; ();

  // Strobe for a single packet
  logic        valid;
  // Payload fields
  mem_cmd_t    cmd;
  mem_source_t source;
  mem_addr_t   address;
  mem_data_t   data;

  // Driving side
  modport src (
    output valid,
    output cmd,
    output source,
    output address,
    output data
  );

  // Receiving side
  modport dst (
    input valid,
    input cmd,
    input source,
    input address,
    input data
  );

endinterface

// File: hdl/round_robin_bus_arbiter.sv
// Round-robin grant among request levels plus a registered one-of-N packet bus over padded lanes
`timescale 1ns/1ps
`include "mem_request_settings.svh"

module round_robin_bus_arbiter import mem_request_pkg::*; #(
  parameter int NUM_LANES = 2**$clog2(`MEM_NUM_REQUESTORS)
) (
  input  logic                 ap_clk,
  input  logic                 areset_control,
  input  logic [NUM_LANES-1:0] request,
  input  logic [NUM_LANES-1:0] bus_valid,
  input  mem_payload_t         bus_in [NUM_LANES-1:0],
  output logic [NUM_LANES-1:0] grant,
  output logic                 bus_out_valid,
  output mem_payload_t         bus_out
);

  localparam int PTR_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  // Lane holding top priority this cycle
  logic [PTR_WIDTH-1:0] rr_ptr;
  logic [NUM_LANES-1:0] grant_next;
  logic [PTR_WIDTH-1:0] grant_idx;
  logic                 grant_any;

  logic         mux_valid;
  mem_payload_t mux_payload;

  // ------------------------------------------------------------
  // Grant selection
  // ------------------------------------------------------------
  // Scan upward from the pointer and wrap by overflow
  always_comb begin
    logic [PTR_WIDTH-1:0] lane_idx;
    grant_next = '0;
    grant_idx  = rr_ptr;
    grant_any  = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_idx = rr_ptr + PTR_WIDTH'(i);
      if (!grant_any && request[lane_idx]) begin
        grant_next[lane_idx] = 1'b1;
        grant_idx            = lane_idx;
        grant_any            = 1'b1;
      end
    end
  end

  // Pointer moves just past the winner
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      rr_ptr <= '0;
      grant  <= '0;
    end else begin
      grant <= grant_next;
      if (grant_any) begin
        rr_ptr <= grant_idx + PTR_WIDTH'(1);
      end
    end
  end

  // ------------------------------------------------------------
  // Packet bus
  // ------------------------------------------------------------
  // At most one lane answers at a time
  always_comb begin
    mux_valid   = |bus_valid;
    mux_payload = bus_in[0];
    for (int i = NUM_LANES - 1; i >= 0; i--) begin
      if (bus_valid[i]) begin
        mux_payload = bus_in[i];
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      bus_out_valid <= 1'b0;
    end else begin
      bus_out_valid <= mux_valid;
    end
  end

  // Payload follows the strobe
  always_ff @(posedge ap_clk) begin
    bus_out <= mux_payload;
  end

endmodule

// File: hdl/request_sync_fifo.sv
// Synchronous request FIFO with registered two-stage read, status flags and a read-valid strobe
`timescale 1ns/1ps
`include "mem_request_settings.svh"

module request_sync_fifo import mem_request_pkg::*; (
  input  logic         ap_clk,
  input  logic         areset_control,
  input  mem_payload_t din,
  input  logic         wr_en,
  input  logic         rd_en,
  output mem_payload_t dout,
  output logic         dout_valid,
  output logic         empty,
  output logic         full,
  output logic         prog_full
);

  localparam int DEPTH      = `MEM_FIFO_DEPTH;
  localparam int ADDR_WIDTH = $clog2(DEPTH);
  localparam int CNT_WIDTH  = ADDR_WIDTH + 1;

  // Entry storage
  mem_payload_t mem [DEPTH];

  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0]  count;

  // First read stage
  mem_payload_t rd_data_q;
  logic         rd_pending;

  logic wr_accept;
  logic rd_accept;

  // ------------------------------------------------------------
  // Accept and status
  // ------------------------------------------------------------
  // Overflow and underflow guards
  assign wr_accept = wr_en & ~full;
  assign rd_accept = rd_en & ~empty;

  assign empty     = (count == '0);
  assign full      = (count == CNT_WIDTH'(DEPTH));
  assign prog_full = (count >= CNT_WIDTH'(`MEM_FIFO_PROG_THRESH));

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      rd_pending <= 1'b0;
      dout_valid <= 1'b0;
    end else begin
      if (wr_accept) begin
        wr_ptr <= wr_ptr + ADDR_WIDTH'(1);
      end
      if (rd_accept) begin
        rd_ptr <= rd_ptr + ADDR_WIDTH'(1);
      end
      // Net change of one entry at most
      case ({wr_accept, rd_accept})
        2'b10:   count <= count + CNT_WIDTH'(1);
        2'b01:   count <= count - CNT_WIDTH'(1);
        default: count <= count;
      endcase
      rd_pending <= rd_accept;
      dout_valid <= rd_pending;
    end
  end

  // ------------------------------------------------------------
  // Data path
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (wr_accept) begin
      mem[wr_ptr] <= din;
    end
    if (rd_accept) begin
      rd_data_q <= mem[rd_ptr];
    end
    // Output stage lines up with dout_valid
    dout <= rd_data_q;
  end

endmodule

// File: hdl/request_arbiter_n_to_1.sv
// N-to-1 memory request arbiter block feeding the request FIFO, instantiated by the top level
`timescale 1ns/1ps
`include "mem_request_settings.svh"

module request_arbiter_n_to_1 import mem_request_pkg::*; (
  input  logic                           ap_clk,
  input  logic                           areset_control,
  mem_request_if.dst                     request_in [`MEM_NUM_REQUESTORS-1:0],
  input  logic [`MEM_NUM_REQUESTORS-1:0] arbiter_request_in,
  output logic [`MEM_NUM_REQUESTORS-1:0] arbiter_grant_out,
  input  logic                           read_enable,
  mem_request_if.src                     request_out,
  output logic                           fifo_empty,
  output logic                           fifo_full,
  output logic                           fifo_prog_full
);

  localparam int NUM_REQUESTORS = `MEM_NUM_REQUESTORS;
  // Arbiter works on a power of two lanes
  localparam int NUM_ARBITER    = 2**$clog2(NUM_REQUESTORS);

  // ------------------------------------------------------------
  // Signals
  // ------------------------------------------------------------
  // Lane inputs before and after the input register
  logic [NUM_REQUESTORS-1:0] lane_valid_d;
  mem_payload_t              lane_payload_d [NUM_REQUESTORS-1:0];
  logic [NUM_REQUESTORS-1:0] lane_valid_q;
  mem_payload_t              lane_payload_q [NUM_REQUESTORS-1:0];

  logic [NUM_REQUESTORS-1:0] arbiter_request_reg;
  logic                      read_enable_reg;

  // Padded arbiter side
  logic [NUM_ARBITER-1:0] arbiter_request;
  logic [NUM_ARBITER-1:0] arbiter_bus_valid;
  mem_payload_t           arbiter_bus_in [NUM_ARBITER-1:0];
  logic [NUM_ARBITER-1:0] arbiter_grant;
  logic                   arbiter_bus_out_valid;
  mem_payload_t           arbiter_bus_out;

  // FIFO side
  logic         fifo_din_valid_q;
  mem_payload_t fifo_din_q;
  logic         fifo_push_filter;
  logic         fifo_wr_en;
  logic         fifo_rd_en;
  mem_payload_t fifo_dout;
  logic         fifo_dout_valid;
  logic         fifo_empty_int;
  logic         fifo_full_int;
  logic         fifo_prog_full_int;

  // ------------------------------------------------------------
  // Input register
  // ------------------------------------------------------------
  // Lane interfaces into packed payloads
  for (genvar i = 0; i < NUM_REQUESTORS; i++) begin : g_lane_in
    assign lane_valid_d[i]   = request_in[i].valid;
    assign lane_payload_d[i] = '{cmd:     request_in[i].cmd,
                                 source:  request_in[i].source,
                                 address: request_in[i].address,
                                 data:    request_in[i].data};
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      lane_valid_q        <= '0;
      arbiter_request_reg <= '0;
      read_enable_reg     <= 1'b0;
    end else begin
      lane_valid_q        <= lane_valid_d;
      arbiter_request_reg <= arbiter_request_in;
      read_enable_reg     <= read_enable;
    end
  end

  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_REQUESTORS; i++) begin
      lane_payload_q[i] <= lane_payload_d[i];
    end
  end

  // ------------------------------------------------------------
  // Bus arbiter
  // ------------------------------------------------------------
  // Unused lanes tied off
  for (genvar i = 0; i < NUM_ARBITER; i++) begin : g_arb_lane
    if (i < NUM_REQUESTORS) begin : g_real
      // Back-pressure holds all new grants
      assign arbiter_request[i]   = arbiter_request_reg[i] & ~fifo_prog_full_int;
      assign arbiter_bus_valid[i] = lane_valid_q[i];
      assign arbiter_bus_in[i]    = lane_payload_q[i];
    end else begin : g_pad
      assign arbiter_request[i]   = 1'b0;
      assign arbiter_bus_valid[i] = 1'b0;
      assign arbiter_bus_in[i]    = '0;
    end
  end

  round_robin_bus_arbiter #(
    .NUM_LANES(NUM_ARBITER)
  ) i_arbiter (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .request       (arbiter_request),
    .bus_valid     (arbiter_bus_valid),
    .bus_in        (arbiter_bus_in),
    .grant         (arbiter_grant),
    .bus_out_valid (arbiter_bus_out_valid),
    .bus_out       (arbiter_bus_out)
  );

  // ------------------------------------------------------------
  // FIFO push and pop
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      fifo_din_valid_q <= 1'b0;
    end else begin
      fifo_din_valid_q <= arbiter_bus_out_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    fifo_din_q <= arbiter_bus_out;
  end

  // Responses never head toward memory
  assign fifo_push_filter = (fifo_din_q.cmd != CMD_MEM_RESPONSE);
  assign fifo_wr_en       = fifo_din_valid_q & fifo_push_filter;
  // Pop only what is there
  assign fifo_rd_en       = read_enable_reg & ~fifo_empty_int;

  request_sync_fifo i_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (fifo_din_q),
    .wr_en         (fifo_wr_en),
    .rd_en         (fifo_rd_en),
    .dout          (fifo_dout),
    .dout_valid    (fifo_dout_valid),
    .empty         (fifo_empty_int),
    .full          (fifo_full_int),
    .prog_full     (fifo_prog_full_int)
  );

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      arbiter_grant_out <= '0;
      request_out.valid <= 1'b0;
      fifo_empty        <= 1'b1;
      fifo_full         <= 1'b0;
      fifo_prog_full    <= 1'b0;
    end else begin
      arbiter_grant_out <= arbiter_grant[NUM_REQUESTORS-1:0];
      request_out.valid <= fifo_dout_valid;
      fifo_empty        <= fifo_empty_int;
      fifo_full         <= fifo_full_int;
      fifo_prog_full    <= fifo_prog_full_int;
    end
  end

  // Payload fields
  always_ff @(posedge ap_clk) begin
    request_out.cmd     <= fifo_dout.cmd;
    request_out.source  <= fifo_dout.source;
    request_out.address <= fifo_dout.address;
    request_out.data    <= fifo_dout.data;
  end

endmodule

// File: hdl/request_arbiter_top.sv
// Top level of the memory request arbiter with flattened per-lane ports, the DUT of the testbench
`timescale 1ns/1ps
`include "mem_request_settings.svh"

module request_arbiter_top import mem_request_pkg::*; (
  input  logic                                               ap_clk,
  input  logic                                               areset_control,
  // Lane packets with lane i at slice i
  input  logic [`MEM_NUM_REQUESTORS-1:0]                     req_valid,
  input  logic [`MEM_NUM_REQUESTORS*$bits(mem_cmd_t)-1:0]    req_cmd,
  input  logic [`MEM_NUM_REQUESTORS*MEM_SOURCE_WIDTH-1:0]    req_source,
  input  logic [`MEM_NUM_REQUESTORS*`MEM_ADDR_WIDTH-1:0]     req_address,
  input  logic [`MEM_NUM_REQUESTORS*`MEM_DATA_WIDTH-1:0]     req_data,
  // Request levels and grant pulses
  input  logic [`MEM_NUM_REQUESTORS-1:0]                     arbiter_request,
  output logic [`MEM_NUM_REQUESTORS-1:0]                     arbiter_grant,
  // Memory side
  input  logic                                               read_enable,
  output logic                                               out_valid,
  output mem_cmd_t                                           out_cmd,
  output mem_source_t                                        out_source,
  output mem_addr_t                                          out_address,
  output mem_data_t                                          out_data,
  output logic                                               fifo_empty,
  output logic                                               fifo_full,
  output logic                                               fifo_prog_full
);

  localparam int NUM_REQUESTORS = `MEM_NUM_REQUESTORS;
  localparam int CMD_WIDTH      = $bits(mem_cmd_t);

  mem_request_if lane_if [NUM_REQUESTORS-1:0] ();
  mem_request_if out_if ();

  // ------------------------------------------------------------
  // Flattened vectors to lane interfaces
  // ------------------------------------------------------------
  for (genvar i = 0; i < NUM_REQUESTORS; i++) begin : g_lane
    assign lane_if[i].valid   = req_valid[i];
    assign lane_if[i].cmd     = mem_cmd_t'(req_cmd[i*CMD_WIDTH +: CMD_WIDTH]);
    assign lane_if[i].source  = req_source[i*MEM_SOURCE_WIDTH +: MEM_SOURCE_WIDTH];
    assign lane_if[i].address = req_address[i*`MEM_ADDR_WIDTH +: `MEM_ADDR_WIDTH];
    assign lane_if[i].data    = req_data[i*`MEM_DATA_WIDTH +: `MEM_DATA_WIDTH];
  end

  request_arbiter_n_to_1 i_arbiter_n_to_1 (
    .ap_clk            (ap_clk),
    .areset_control    (areset_control),
    .request_in        (lane_if),
    .arbiter_request_in(arbiter_request),
    .arbiter_grant_out (arbiter_grant),
    .read_enable       (read_enable),
    .request_out       (out_if),
    .fifo_empty        (fifo_empty),
    .fifo_full         (fifo_full),
    .fifo_prog_full    (fifo_prog_full)
  );

  // Output packet back to plain ports
  assign out_valid   = out_if.valid;
  assign out_cmd     = out_if.cmd;
  assign out_source  = out_if.source;
  assign out_address = out_if.address;
  assign out_data    = out_if.data;

endmodule

// File: dv/request_arbiter_checker.sv
// Concurrent assertions on the arbiter block, attached to request_arbiter_n_to_1 by bind
`timescale 1ns/1ps
`include "mem_request_settings.svh"

module request_arbiter_checker import mem_request_pkg::*; #(
  parameter int NUM_ARBITER = 2**$clog2(`MEM_NUM_REQUESTORS)
) (
  input logic                           ap_clk,
  input logic                           areset_control,
  input logic [`MEM_NUM_REQUESTORS-1:0] grant_out,
  input logic [NUM_ARBITER-1:0]         arb_grant,
  input logic                           prog_full,
  input logic                           fifo_wr_en,
  input logic                           fifo_full,
  input logic                           dout_valid,
  input mem_cmd_t                       dout_cmd
);

  // ------------------------------------------------------------
  // Grant rules
  // ------------------------------------------------------------
  // One lane per cycle at most
  a_grant_onehot: assert property (@(posedge ap_clk) disable iff (areset_control)
    $onehot0(grant_out)) else $error("grant output is not one-hot or zero");

  // Back-pressure stops the next grant
  a_prog_full_mask: assert property (@(posedge ap_clk) disable iff (areset_control)
    prog_full |=> (arb_grant == '0)) else $error("grant issued while FIFO programmable-full");

  // ------------------------------------------------------------
  // FIFO guards and output
  // ------------------------------------------------------------
  a_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_control)
    !(fifo_wr_en && fifo_full)) else $error("FIFO write while full");

  // Filtered commands never leave the FIFO
  a_no_response_out: assert property (@(posedge ap_clk) disable iff (areset_control)
    dout_valid |-> (dout_cmd != CMD_MEM_RESPONSE)) else $error("response command popped");

endmodule

// File: dv/request_arbiter_tb.sv
// Self-checking testbench for the request arbiter top, built and run by the Makefile
`timescale 1ns/1ps
`include "mem_request_settings.svh"

module request_arbiter_tb import mem_request_pkg::*; ();

  localparam int NUM_LANES = `MEM_NUM_REQUESTORS;
  localparam int CMD_W     = $bits(mem_cmd_t);
  localparam int SRC_W     = MEM_SOURCE_WIDTH;
  localparam int ADDR_W    = `MEM_ADDR_WIDTH;
  localparam int DATA_W    = `MEM_DATA_WIDTH;
  localparam logic [NUM_LANES-1:0] ALL_LANES = '1;

  // ------------------------------------------------------------
  // DUT signals
  // ------------------------------------------------------------
  logic                        ap_clk = 1'b0;
  logic                        areset_control;
  logic [NUM_LANES-1:0]        req_valid = '0;
  logic [NUM_LANES*CMD_W-1:0]  req_cmd = '0;
  logic [NUM_LANES*SRC_W-1:0]  req_source = '0;
  logic [NUM_LANES*ADDR_W-1:0] req_address = '0;
  logic [NUM_LANES*DATA_W-1:0] req_data = '0;
  logic [NUM_LANES-1:0]        arbiter_request = '0;
  logic [NUM_LANES-1:0]        arbiter_grant;
  logic                        read_enable;
  logic                        out_valid;
  mem_cmd_t                    out_cmd;
  mem_source_t                 out_source;
  mem_addr_t                   out_address;
  mem_data_t                   out_data;
  logic                        fifo_empty;
  logic                        fifo_full;
  logic                        fifo_prog_full;

  // Per-lane packets still to send and still to see
  mem_payload_t send_q [NUM_LANES][$];
  mem_payload_t exp_q  [NUM_LANES][$];

  logic [31:0]          lfsr_state = 32'd67665;
  int                   error_count = 0;
  int                   timeout_count = 0;
  int                   packets_checked = 0;
  int                   grant_total = 0;
  bit                   full_reported = 1'b0;
  logic [NUM_LANES-1:0] grant_seen = '0;
  // Request levels of the last three negedges
  logic [NUM_LANES-1:0] req_hist [3];
  logic [NUM_LANES-1:0] fair_win [$];

  always #20 ap_clk = ~ap_clk;

  request_arbiter_top i_dut (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .req_valid      (req_valid),
    .req_cmd        (req_cmd),
    .req_source     (req_source),
    .req_address    (req_address),
    .req_data       (req_data),
    .arbiter_request(arbiter_request),
    .arbiter_grant  (arbiter_grant),
    .read_enable    (read_enable),
    .out_valid      (out_valid),
    .out_cmd        (out_cmd),
    .out_source     (out_source),
    .out_address    (out_address),
    .out_data       (out_data),
    .fifo_empty     (fifo_empty),
    .fifo_full      (fifo_full),
    .fifo_prog_full (fifo_prog_full)
  );

  bind request_arbiter_n_to_1 request_arbiter_checker i_checker (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .grant_out     (arbiter_grant_out),
    .arb_grant     (arbiter_grant),
    .prog_full     (fifo_prog_full_int),
    .fifo_wr_en    (fifo_wr_en),
    .fifo_full     (fifo_full_int),
    .dout_valid    (fifo_dout_valid),
    .dout_cmd      (fifo_dout.cmd)
  );

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  // Galois LFSR, one step per bit
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    logic        lsb;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lsb ? 32'h8020_0003 : 32'h0);
      value      = {value[30:0], lsb};
    end
    return value;
  endfunction

  // Random packets for one lane; responses are never expected out
  task automatic load_lane(input int lane, input int count);
    mem_payload_t pkt;
    logic [31:0]  bits;
    for (int n = 0; n < count; n++) begin
      bits        = random_bits(CMD_W);
      pkt.cmd     = mem_cmd_t'(bits[CMD_W-1:0]);
      pkt.source  = mem_source_t'(lane);
      pkt.address = random_bits(ADDR_W);
      pkt.data    = random_bits(DATA_W);
      send_q[lane].push_back(pkt);
      if (pkt.cmd != CMD_MEM_RESPONSE) begin
        exp_q[lane].push_back(pkt);
      end
    end
  endtask

  function automatic bit all_drained();
    for (int i = 0; i < NUM_LANES; i++) begin
      if (send_q[i].size() != 0 || exp_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // Reads on, or toggled at random, until every packet is seen
  task automatic wait_drain(input bit random_read, input int limit);
    int          cycles;
    logic [31:0] bits;
    cycles = 0;
    @(posedge ap_clk);
    read_enable <= 1'b1;
    while (!all_drained() && cycles < limit) begin
      @(posedge ap_clk);
      if (random_read) begin
        bits = random_bits(1);
        read_enable <= bits[0];
      end
      @(negedge ap_clk);
      cycles++;
    end
    @(posedge ap_clk);
    read_enable <= 1'b1;
    if (!all_drained()) begin
      timeout_count++;
      $display("Timeout: packets still pending after %0d cycles", limit);
    end
  endtask

  task automatic wait_prog_full(input int limit);
    int cycles;
    cycles = 0;
    while (!fifo_prog_full && cycles < limit) begin
      @(negedge ap_clk);
      cycles++;
    end
    if (!fifo_prog_full) begin
      timeout_count++;
      $display("Timeout: programmable-full never rose with reads held off");
    end
  endtask

  // ------------------------------------------------------------
  // Requester lanes
  // ------------------------------------------------------------
  // One packet per grant seen in the previous cycle
  always @(posedge ap_clk) begin
    mem_payload_t pkt;
    if (areset_control) begin
      req_valid       <= '0;
      arbiter_request <= '0;
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (grant_seen[i] && send_q[i].size() > 0) begin
          pkt = send_q[i].pop_front();
          req_valid[i]                     <= 1'b1;
          req_cmd[i*CMD_W +: CMD_W]        <= pkt.cmd;
          req_source[i*SRC_W +: SRC_W]     <= pkt.source;
          req_address[i*ADDR_W +: ADDR_W]  <= pkt.address;
          req_data[i*DATA_W +: DATA_W]     <= pkt.data;
        end else begin
          req_valid[i] <= 1'b0;
        end
        // Level stays up while packets wait
        arbiter_request[i] <= (send_q[i].size() > 0);
      end
    end
  end

  // ------------------------------------------------------------
  // Monitor and reference model
  // ------------------------------------------------------------
  always @(negedge ap_clk) begin
    mem_payload_t         exp_pkt;
    logic [NUM_LANES-1:0] fair_or;
    int                   src;
    grant_seen = arbiter_grant;
    if (areset_control) begin
      req_hist[0] = '0;
      req_hist[1] = '0;
      req_hist[2] = '0;
      fair_win.delete();
    end else begin
      if (!$onehot0(arbiter_grant)) begin
        error_count++;
        $display("Fail @%0t: grant is not one-hot %b", $time, arbiter_grant);
      end
      // Grant answers the request of three cycles back
      if ((arbiter_grant & ~req_hist[2]) != '0) begin
        error_count++;
        $display("Fail @%0t: grant %b went to a lane that was not requesting",
                 $time, arbiter_grant);
      end
      if (arbiter_grant != '0) begin
        grant_total++;
        if (req_hist[2] == ALL_LANES) begin
          fair_win.push_back(arbiter_grant);
          if (fair_win.size() == NUM_LANES) begin
            fair_or = '0;
            for (int k = 0; k < NUM_LANES; k++) begin
              fair_or |= fair_win[k];
            end
            if (fair_or != ALL_LANES) begin
              error_count++;
              $display("Fail @%0t: round-robin window skipped a lane %b", $time, fair_or);
            end
            void'(fair_win.pop_front());
          end
        end else begin
          fair_win.delete();
        end
      end
      req_hist[2] = req_hist[1];
      req_hist[1] = req_hist[0];
      req_hist[0] = arbiter_request;
      if (fifo_full && !full_reported) begin
        full_reported = 1'b1;
        error_count++;
        $display("Fail @%0t: FIFO reported full", $time);
      end
      // Output packet against the lane's expected order
      if (out_valid) begin
        src = int'(out_source);
        if (out_cmd == CMD_MEM_RESPONSE) begin
          error_count++;
          $display("Fail @%0t: response command reached the output", $time);
        end else if (src >= NUM_LANES || exp_q[src].size() == 0) begin
          error_count++;
          $display("Fail @%0t: unexpected packet with source %0d", $time, src);
        end else begin
          exp_pkt = exp_q[src].pop_front();
          packets_checked++;
          if (exp_pkt.cmd != out_cmd || exp_pkt.address != out_address ||
              exp_pkt.data != out_data) begin
            error_count++;
            $display("Fail @%0t: lane %0d expected cmd=%0d addr=%h data=%h, got %0d %h %h",
                     $time, src, exp_pkt.cmd, exp_pkt.address, exp_pkt.data,
                     out_cmd, out_address, out_data);
          end
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    int          grants_before;
    logic [31:0] bits;
    areset_control = 1'b1;
    read_enable    = 1'b0;
    repeat (8) @(posedge ap_clk);
    areset_control <= 1'b0;

    // Reset state
    @(negedge ap_clk);
    if (out_valid !== 1'b0 || arbiter_grant !== '0 || fifo_empty !== 1'b1 ||
        fifo_full !== 1'b0 || fifo_prog_full !== 1'b0) begin
      error_count++;
      $display("Fail @%0t: after reset valid=%b grant=%b empty=%b full=%b prog_full=%b",
               $time, out_valid, arbiter_grant, fifo_empty, fifo_full, fifo_prog_full);
    end
    // Idle with reads on and no requests
    @(posedge ap_clk);
    read_enable <= 1'b1;
    repeat (20) @(posedge ap_clk);

    // All lanes busy with free-running reads
    @(negedge ap_clk);
    for (int i = 0; i < NUM_LANES; i++) begin
      load_lane(i, 40);
    end
    wait_drain(1'b0, 4000);

    // Back-pressure with reads held off
    @(posedge ap_clk);
    read_enable <= 1'b0;
    @(negedge ap_clk);
    for (int i = 0; i < NUM_LANES; i++) begin
      load_lane(i, 24);
    end
    wait_prog_full(1000);
    // Grants already in flight settle first
    repeat (3) @(posedge ap_clk);
    grants_before = grant_total;
    repeat (30) @(posedge ap_clk);
    if (grant_total != grants_before) begin
      error_count++;
      $display("Fail @%0t: grants continued while the FIFO was programmable-full", $time);
    end
    wait_drain(1'b0, 4000);

    // Random loads with random reads
    for (int r = 0; r < 6; r++) begin
      @(negedge ap_clk);
      for (int i = 0; i < NUM_LANES; i++) begin
        bits = random_bits(4);
        load_lane(i, int'(bits[3:0]));
      end
      wait_drain(1'b1, 4000);
    end

    // Stragglers would show as unexpected packets
    repeat (20) @(negedge ap_clk);
    if (fifo_empty !== 1'b1) begin
      error_count++;
      $display("Fail @%0t: FIFO not empty at the end", $time);
    end
    $display("Summary: %0d packets checked, %0d errors, %0d timeouts",
             packets_checked, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
+incdir+include
hdl/mem_request_pkg.sv
hdl/mem_request_if.sv
hdl/round_robin_bus_arbiter.sv
hdl/request_sync_fifo.sv
hdl/request_arbiter_n_to_1.sv
hdl/request_arbiter_top.sv
dv/request_arbiter_checker.sv
dv/request_arbiter_tb.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only -Wall --timing --assert --timescale 1ns/1ps
TOP        = request_arbiter_tb
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_TEXT  = Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
